// ==== rv_pkg.sv ====
package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc_plus4
    } result_src_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_from_mem,
        fwd_from_wb
    } forward_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_plus4;
        logic [31:0] instr;
    } fd_reg_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic        jump;
        logic        branch;
        // set for bne, clear for beq
        logic        branch_ne;
        alu_op_e     alu_op;
        logic        alu_src;
    } de_ctrl_t;

    typedef struct packed {
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] pc;
        logic [31:0] pc_plus4;
        logic [31:0] imm_ext;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
    } de_data_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic [31:0] alu_result;
        logic [31:0] write_data;
        logic [4:0]  rd;
        logic [31:0] pc_plus4;
    } em_reg_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic [31:0] alu_result;
        logic [31:0] read_data;
        logic [4:0]  rd;
        logic [31:0] pc_plus4;
    } mw_reg_t;

endpackage

// ==== instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::fd_reg_t  fd,
    input  logic [4:0]       rd_w,
    input  logic [31:0]      result_w,
    input  logic             reg_write_w,
    output rv_pkg::de_ctrl_t ctrl,
    output rv_pkg::de_data_t data
);
    import rv_pkg::*;

    logic [31:0] regs [32];
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7_5;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    logic [31:0] imm_ext;

    assign opcode   = fd.instr[6:0];
    assign funct3   = fd.instr[14:12];
    assign funct7_5 = fd.instr[30];
    assign rs1      = fd.instr[19:15];
    assign rs2      = fd.instr[24:20];

    // falling edge write, so a same-cycle read sees the new value
    always_ff @(negedge clk) begin
        if (reg_write_w && rd_w != 5'd0) begin
            regs[rd_w] <= result_w;
        end
    end

    assign imm_i = {{20{fd.instr[31]}}, fd.instr[31:20]};
    assign imm_s = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
    assign imm_b = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7], fd.instr[30:25],
                    fd.instr[11:8], 1'b0};
    assign imm_j = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12], fd.instr[20],
                    fd.instr[30:21], 1'b0};
    assign imm_u = {fd.instr[31:12], 12'b0};

    // shared by register and immediate arithmetic
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b010:  return alu_slt;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    always_comb begin
        ctrl    = '0;
        imm_ext = '0;
        case (opcode_e'(opcode))
            opc_op: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, funct7_5);
            end
            opc_op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, 1'b0);
                imm_ext        = imm_i;
            end
            opc_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_pass_b;
                imm_ext        = imm_u;
            end
            opc_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = res_mem;
                ctrl.alu_src    = 1'b1;
                imm_ext         = imm_i;
            end
            opc_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm_ext        = imm_s;
            end
            opc_branch: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                imm_ext        = imm_b;
            end
            opc_jal: begin
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = res_pc_plus4;
                ctrl.jump       = 1'b1;
                imm_ext         = imm_j;
            end
            default: ;
        endcase
    end

    always_comb begin
        data.rd1      = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
        data.rd2      = (rs2 == 5'd0) ? 32'd0 : regs[rs2];
        data.pc       = fd.pc;
        data.pc_plus4 = fd.pc_plus4;
        data.imm_ext  = imm_ext;
        data.rs1      = rs1;
        data.rs2      = rs2;
        data.rd       = fd.instr[11:7];
    end

    // zeroed flush words land here too
    unknown_op_no_write: assert property (@(posedge clk) disable iff (rst)
        !(opcode inside {opc_op, opc_op_imm, opc_lui, opc_load, opc_store, opc_branch,
                         opc_jal}) |-> !ctrl.reg_write && !ctrl.mem_write)
        else $error("unknown opcode %h decoded with a write enable", opcode);

endmodule

// ==== exec.sv ====
`timescale 1ns/1ps

module exec (
    input  rv_pkg::de_ctrl_t ctrl,
    input  rv_pkg::de_data_t data,
    input  rv_pkg::forward_e forward_a,
    input  rv_pkg::forward_e forward_b,
    input  logic [31:0]      alu_result_m,
    input  logic [31:0]      result_w,
    output rv_pkg::em_reg_t  em,
    output logic             pc_src,
    output logic [31:0]      pc_target
);
    import rv_pkg::*;

    logic [31:0] src_a;
    logic [31:0] rs2_val;
    logic [31:0] src_b;
    logic [31:0] alu_result;
    logic        equal;

    // operand A, newest producer wins
    always_comb begin
        case (forward_a)
            fwd_from_mem: src_a = alu_result_m;
            fwd_from_wb:  src_a = result_w;
            default:      src_a = data.rd1;
        endcase
    end

    always_comb begin
        case (forward_b)
            fwd_from_mem: rs2_val = alu_result_m;
            fwd_from_wb:  rs2_val = result_w;
            default:      rs2_val = data.rd2;
        endcase
    end

    assign src_b = ctrl.alu_src ? data.imm_ext : rs2_val;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub:    alu_result = src_a - src_b;
            alu_and:    alu_result = src_a & src_b;
            alu_or:     alu_result = src_a | src_b;
            alu_slt:    alu_result = {31'd0, $signed(src_a) < $signed(src_b)};
            alu_pass_b: alu_result = src_b;
            default:    alu_result = src_a + src_b;
        endcase
    end

    // beq takes on equal, bne on not equal
    assign equal     = (src_a == rs2_val);
    assign pc_src    = ctrl.jump || (ctrl.branch && (equal != ctrl.branch_ne));
    assign pc_target = data.pc + data.imm_ext;

    always_comb begin
        em.reg_write  = ctrl.reg_write;
        em.result_src = ctrl.result_src;
        em.mem_write  = ctrl.mem_write;
        em.alu_result = alu_result;
        // store data must carry the forwarded value
        em.write_data = rs2_val;
        em.rd         = data.rd;
        em.pc_plus4   = data.pc_plus4;
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic                [4:0] rs1_d,
    input  logic                [4:0] rs2_d,
    input  logic                [4:0] rs1_e,
    input  logic                [4:0] rs2_e,
    input  logic                [4:0] rd_e,
    input  logic                [4:0] rd_m,
    input  logic                [4:0] rd_w,
    input  rv_pkg::result_src_e       result_src_e,
    input  logic                      reg_write_m,
    input  logic                      reg_write_w,
    input  logic                      pc_src_e,
    output logic                      stall_f,
    output logic                      stall_d,
    output logic                      flush_d,
    output logic                      flush_e,
    output rv_pkg::forward_e          forward_a_e,
    output rv_pkg::forward_e          forward_b_e
);
    import rv_pkg::*;

    logic lw_stall;

    // memory stage result is younger, so it is checked first
    function automatic forward_e fwd_sel(input logic [4:0] rs);
        if (reg_write_m && rd_m != 5'd0 && rd_m == rs) begin
            return fwd_from_mem;
        end else if (reg_write_w && rd_w != 5'd0 && rd_w == rs) begin
            return fwd_from_wb;
        end
        return fwd_none;
    endfunction

    assign forward_a_e = fwd_sel(rs1_e);
    assign forward_b_e = fwd_sel(rs2_e);

    always_comb begin
        lw_stall = (result_src_e == res_mem) && rd_e != 5'd0 &&
                   (rd_e == rs1_d || rd_e == rs2_d);
        stall_f  = lw_stall;
        stall_d  = lw_stall;
        flush_d  = pc_src_e;
        flush_e  = lw_stall || pc_src_e;
        // a held pc with a cleared decode word would drop an instruction
        assert (!(stall_f && flush_d && !stall_d))
            else $error("fetch stalled while decode flushed and running");
    end

endmodule

// ==== riscv_pipeline.sv ====
`timescale 1ns/1ps

module riscv_pipeline #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    output logic [31:0] pc,
    input  logic [31:0] read_data,
    output logic        data_we,
    output logic [31:0] data_addr,
    output logic [31:0] din
);
    import rv_pkg::*;

    logic [31:0] pc_plus4_f;
    logic [31:0] pc_target_e;
    logic        pc_src_e;
    logic        stall_f;
    logic        stall_d;
    logic        flush_d;
    logic        flush_e;
    forward_e    forward_a_e;
    forward_e    forward_b_e;
    fd_reg_t     fd_next;
    fd_reg_t     fd_q;
    de_ctrl_t    ctrl_d;
    de_data_t    data_d;
    de_ctrl_t    ctrl_e;
    de_data_t    data_e;
    em_reg_t     em_next;
    em_reg_t     em_q;
    mw_reg_t     mw_next;
    mw_reg_t     mw_q;
    logic [4:0]  rd_w;
    logic [31:0] result_w;
    logic        reg_write_w;

    // fetch
    assign pc_plus4_f = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (!stall_f) begin
            pc <= pc_src_e ? pc_target_e : pc_plus4_f;
        end
    end

    assign fd_next = '{pc: pc, pc_plus4: pc_plus4_f, instr: instr};

    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            fd_q <= '0;
        end else if (!stall_d) begin
            fd_q <= fd_next;
        end
    end

    instr_decode i_instr_decode (
        .clk(clk),
        .rst(rst),
        .fd(fd_q),
        .rd_w(rd_w),
        .result_w(result_w),
        .reg_write_w(reg_write_w),
        .ctrl(ctrl_d),
        .data(data_d)
    );

    // execute register, a flush leaves a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            ctrl_e <= '0;
        end else begin
            ctrl_e <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        data_e <= data_d;
    end

    exec i_exec (
        .ctrl(ctrl_e),
        .data(data_e),
        .forward_a(forward_a_e),
        .forward_b(forward_b_e),
        .alu_result_m(em_q.alu_result),
        .result_w(result_w),
        .em(em_next),
        .pc_src(pc_src_e),
        .pc_target(pc_target_e)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            em_q <= '0;
        end else begin
            em_q <= em_next;
        end
    end

    // memory access
    assign data_we   = em_q.mem_write;
    assign data_addr = em_q.alu_result;
    assign din       = em_q.write_data;

    assign mw_next = '{reg_write: em_q.reg_write, result_src: em_q.result_src,
                       alu_result: em_q.alu_result, read_data: read_data,
                       rd: em_q.rd, pc_plus4: em_q.pc_plus4};

    always_ff @(posedge clk) begin
        if (rst) begin
            mw_q <= '0;
        end else begin
            mw_q <= mw_next;
        end
    end

    // write back
    always_comb begin
        case (mw_q.result_src)
            res_mem:      result_w = mw_q.read_data;
            res_pc_plus4: result_w = mw_q.pc_plus4;
            default:      result_w = mw_q.alu_result;
        endcase
    end

    assign rd_w        = mw_q.rd;
    assign reg_write_w = mw_q.reg_write;

    hazard_unit i_hazard_unit (
        .rs1_d(data_d.rs1),
        .rs2_d(data_d.rs2),
        .rs1_e(data_e.rs1),
        .rs2_e(data_e.rs2),
        .rd_e(data_e.rd),
        .rd_m(em_q.rd),
        .rd_w(rd_w),
        .result_src_e(ctrl_e.result_src),
        .reg_write_m(em_q.reg_write),
        .reg_write_w(reg_write_w),
        .pc_src_e(pc_src_e),
        .stall_f(stall_f),
        .stall_d(stall_d),
        .flush_d(flush_d),
        .flush_e(flush_e),
        .forward_a_e(forward_a_e),
        .forward_b_e(forward_b_e)
    );

    word_aligned_store: assert property (@(posedge clk) disable iff (rst)
        data_we |-> data_addr[1:0] == 2'b00)
        else $error("misaligned store to %h", data_addr);

endmodule

// ==== tb_riscv_pipeline.sv ====
`timescale 1ns/1ps

module tb_riscv_pipeline;
    localparam int mem_words = 256;
    localparam logic [31:0] start_pc = 32'h0000_0000;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] read_data;
    logic        data_we;
    logic [31:0] data_addr;
    logic [31:0] din;

    logic [31:0] patterns [64];
    logic [31:0] rom [mem_words];
    logic [31:0] ram [mem_words];
    logic [31:0] end_pc;
    int          prog_len;
    int          store_count;
    int          store_base;
    int          cycle_limit;
    int          stores_seen = 0;
    int          cycles = 0;
    int          end_hits = 0;
    int          group = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_done = 0;
    int          reset_edges = 0;
    bit          reset_seen = 1'b0;

    riscv_pipeline #(.reset_pc(start_pc)) dut_i (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .read_data(read_data),
        .data_we(data_we),
        .data_addr(data_addr),
        .din(din)
    );

    always #4 clk = ~clk;

    // both memories answer in the same cycle
    assign instr     = rom[pc[9:2]];
    assign read_data = ram[data_addr[9:2]];

    always @(posedge clk) begin
        if (data_we) begin
            ram[data_addr[9:2]] <= din;
        end
    end

    function automatic string group_name(input int g);
        case (g)
            0:       return "alu_forwarding";
            1:       return "load_use";
            2:       return "branch_skip";
            default: return "jal_link";
        endcase
    endfunction

    // index of the last store in each group of the program
    function automatic int group_last(input int g);
        case (g)
            0:       return 5;
            1:       return 6;
            2:       return 7;
            default: return 9;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic close_test(input string name);
        $display("test %-15s %0d mismatches", name, test_errors);
        tests_done++;
        test_errors = 0;
    endtask

    // store monitor, samples the values of the cycle that just ended
    always @(posedge clk) begin
        if (rst) begin
            // registers hold their reset values from the first reset edge on
            if (reset_edges > 0) begin
                check("data_we", {31'd0, data_we}, 32'd0);
                check("pc", pc, start_pc);
            end
            reset_edges++;
        end else begin
            if (!reset_seen) begin
                close_test("reset_quiet");
                reset_seen = 1'b1;
            end
            cycles++;
            if (data_we) begin
                if (stores_seen < store_count) begin
                    check("data_addr", data_addr, patterns[store_base + 2 * stores_seen]);
                    check("din", din, patterns[store_base + 2 * stores_seen + 1]);
                    if (stores_seen == group_last(group)) begin
                        close_test(group_name(group));
                        group++;
                    end
                end else begin
                    $display("extra store to address %h at %0t, none was expected",
                             data_addr, $time);
                    errors++;
                    test_errors++;
                end
                stores_seen++;
            end
            if (pc == end_pc) begin
                end_hits++;
            end
        end
    end

    initial begin
        rst <= 1'b1;
        $readmemh("riscv_patterns.hex", patterns);
        prog_len    = patterns[0];
        store_count = patterns[prog_len + 1];
        store_base  = prog_len + 2;
        end_pc      = (prog_len - 1) * 4;
        cycle_limit = 20 * prog_len + 100;
        for (int i = 0; i < mem_words; i++) begin
            rom[i] = (i < prog_len) ? patterns[i + 1] : 32'h0000_0013;
            ram[i] <= i * 16 + 3;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // final self-jump seen twice means the pipeline has drained
        wait (end_hits >= 2 || cycles >= cycle_limit);
        if (end_hits >= 2) begin
            check("store count", stores_seen, store_count);
            close_test("store_count");
            $display("%0d tests, %0d errors", tests_done, errors);
            if (errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
        end else begin
            $display("timeout: the program did not reach its final jump in %0d cycles",
                     cycle_limit);
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== riscv_patterns.hex ====
// word 0 program length, then the program words, then the store count,
// then one line per expected store: address data
00000021
// alu and immediate chain, forwarding from memory and write back
00900093 00E00113 002081B3 40118233
003272B3 0012E333 0062A3B3 12345437
67840493
// store the chain results
10302023 10402223 10502423 10602623
10702823 10902A23
// load then immediate use, store the sum
01402503 001505B3 10B02C23
// taken beq, taken bne, each over two stores
00108663 18102023 18102223
00209663 18102423 18102623
// not taken beq, its store goes through
00208663 10202E23
// jal over two stores, link and sum stored at the target
00C0066F 18102823 18102A23
00B606B3 12C02023 12D02223
// final self-jump
0000006F
0000000A
00000100 00000017
00000104 0000000E
00000108 00000006
0000010C 0000000F
00000110 00000001
00000114 12345678
00000118 0000005C
0000011C 0000000E
00000120 0000006C
00000124 000000C8

// ==== verilog.f ====
rv_pkg.sv
instr_decode.sv
exec.sv
hazard_unit.sv
riscv_pipeline.sv
tb_riscv_pipeline.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_riscv_pipeline
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
